// File: pwm_defs.svh
/*
  Fixed constants of the PWM chain: channel count, data widths and the
  register map. Include this wherever a width or an address is needed.
*/
`ifndef PWM_DEFS_SVH
`define PWM_DEFS_SVH

`define PWM_CHANNELS 3
`define PWM_COUNT_WIDTH 16
`define PWM_ADDR_WIDTH 4
// Compare index is channel * 2 + select, so it spans 0 to 5
`define PWM_INDEX_WIDTH 3

`define PWM_REG_CONTROL 4'd0
`define PWM_REG_DELAY 4'd1
`define PWM_REG_START 4'd2
`define PWM_REG_STOP 4'd3
`define PWM_REG_COMPARE_BASE 4'd4
`define PWM_REG_DEADTIME_BASE 4'd10
`define PWM_REG_OUTPUT 4'd13

`endif

// File: pwm_pkg.sv
/*
  Types shared by the PWM chain modules. Modules pull them in with a
  wildcard import in their header.
*/
`default_nettype none

`include "pwm_defs.svh"

package pwm_pkg;

    typedef logic [`PWM_COUNT_WIDTH-1:0] count_t;
    typedef logic [`PWM_COUNT_WIDTH-1:0] dead_time_t;
    typedef logic [`PWM_ADDR_WIDTH-1:0] reg_addr_t;

    typedef enum logic {mode_sawtooth, mode_triangle} counter_mode_t;

    // Counter start sequence
    typedef enum logic [1:0] {state_idle, state_delay, state_run} counter_state_t;

endpackage

`default_nettype wire

// File: count_if.sv
/*
  Count value and period events from the PWM counter to the compare bank.
  The counter takes the producer side, the compare bank the buffer side.
*/
`timescale 1ns/100ps
`default_nettype none

interface count_if import pwm_pkg::*; ();

    count_t count;
    logic reload;
    logic running;
    logic counting_down;

    modport producer (output count, reload, running, counting_down);
    modport buffer (input count, reload, running, counting_down);

endinterface

`default_nettype wire

// File: pwm_registers.sv
/*
  Register write decoder of the PWM chain. Writes become configuration
  levels one cycle later, and compare writes become a one-cycle strobe
  with a channel/select index and the value for the compare bank.
*/
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_registers import pwm_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic reg_write,
    input  reg_addr_t reg_address,
    input  count_t reg_data,
    output logic run,
    output counter_mode_t mode,
    output count_t delay,
    output count_t start_value,
    output count_t stop_value,
    output logic compare_write,
    output logic [`PWM_INDEX_WIDTH-1:0] compare_index,
    output count_t compare_value,
    output logic [`PWM_CHANNELS-1:0] output_enable,
    output logic [`PWM_CHANNELS-1:0] dead_time_enable,
    output dead_time_t [`PWM_CHANNELS-1:0] dead_times
);

    reg_addr_t compare_offset;
    reg_addr_t dead_time_offset;
    logic is_compare;
    logic is_dead_time;

    assign compare_offset = reg_address - `PWM_REG_COMPARE_BASE;
    assign dead_time_offset = reg_address - `PWM_REG_DEADTIME_BASE;

    assign is_compare = reg_write && reg_address >= `PWM_REG_COMPARE_BASE &&
                        compare_offset < 2 * `PWM_CHANNELS;
    assign is_dead_time = reg_write && reg_address >= `PWM_REG_DEADTIME_BASE &&
                          dead_time_offset < `PWM_CHANNELS;

    always_ff @(posedge clock) begin
        if (!reset) begin
            run <= 1'b0;
            mode <= mode_sawtooth;
            delay <= '0;
            start_value <= '0;
            stop_value <= '0;
            compare_write <= 1'b0;
            output_enable <= '0;
            dead_time_enable <= '0;
            dead_times <= '0;
        end else begin
            compare_write <= is_compare;
            if (reg_write) begin
                case (reg_address)
                    `PWM_REG_CONTROL: begin
                        run <= reg_data[0];
                        mode <= counter_mode_t'(reg_data[1]);
                    end
                    `PWM_REG_DELAY: delay <= reg_data;
                    `PWM_REG_START: start_value <= reg_data;
                    `PWM_REG_STOP: stop_value <= reg_data;
                    `PWM_REG_OUTPUT: begin
                        output_enable <= reg_data[`PWM_CHANNELS-1:0];
                        dead_time_enable <= reg_data[`PWM_CHANNELS+3:4];
                    end
                    default: ;
                endcase
            end
            if (is_dead_time) begin
                dead_times[dead_time_offset] <= reg_data;
            end
        end
    end

    // Compare payload travels alongside the strobe
    always_ff @(posedge clock) begin
        if (is_compare) begin
            compare_index <= compare_offset[`PWM_INDEX_WIDTH-1:0];
            compare_value <= reg_data;
        end
    end

endmodule

`default_nettype wire

// File: pwm_counter.sv
/*
  Shared PWM counter. After the run request rises it waits the start
  delay, then counts timebase pulses as a sawtooth or a triangle between
  the start and stop values and pulses reload once per period or on sync.
*/
`timescale 1ns/100ps
`default_nettype none

module pwm_counter import pwm_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic timebase,
    input  logic sync,
    input  logic run_request,
    input  counter_mode_t mode,
    input  count_t delay,
    input  count_t start_value,
    input  count_t stop_value,
    count_if.producer count_bus
);

    counter_state_t state;
    count_t delay_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= state_idle;
            delay_count <= '0;
            count_bus.count <= '0;
            count_bus.reload <= 1'b0;
            count_bus.running <= 1'b0;
            count_bus.counting_down <= 1'b0;
        end else begin
            count_bus.reload <= 1'b0;
            // Running follows state_run one edge later and drops as soon as the request goes
            count_bus.running <= (state == state_run) && run_request;
            case (state)
                state_idle: begin
                    if (run_request) begin
                        if (delay == '0) begin
                            state <= state_run;
                            count_bus.count <= start_value;
                            count_bus.counting_down <= 1'b0;
                        end else begin
                            state <= state_delay;
                            delay_count <= delay - 1'b1;
                        end
                    end
                end
                state_delay: begin
                    if (!run_request) begin
                        state <= state_idle;
                    end else if (delay_count == '0) begin
                        state <= state_run;
                        count_bus.count <= start_value;
                        count_bus.counting_down <= 1'b0;
                    end else begin
                        delay_count <= delay_count - 1'b1;
                    end
                end
                state_run: begin
                    if (!run_request) begin
                        state <= state_idle;
                    end else if (sync) begin
                        count_bus.count <= start_value;
                        count_bus.counting_down <= 1'b0;
                        count_bus.reload <= 1'b1;
                    end else if (timebase && count_bus.running) begin
                        if (mode == mode_sawtooth) begin
                            count_bus.counting_down <= 1'b0;
                            if (count_bus.count == stop_value) begin
                                count_bus.count <= start_value;
                                count_bus.reload <= 1'b1;
                            end else begin
                                count_bus.count <= count_bus.count + 1'b1;
                            end
                        end else if (!count_bus.counting_down) begin
                            if (count_bus.count == stop_value) begin
                                count_bus.counting_down <= 1'b1;
                                count_bus.count <= count_bus.count - 1'b1;
                            end else begin
                                count_bus.count <= count_bus.count + 1'b1;
                            end
                        end else if (count_bus.count == start_value) begin
                            // Turning at the bottom closes the triangle period
                            count_bus.counting_down <= 1'b0;
                            count_bus.count <= count_bus.count + 1'b1;
                            count_bus.reload <= 1'b1;
                        end else begin
                            count_bus.count <= count_bus.count - 1'b1;
                        end
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // The compare bank relies on reload being a single-cycle event
    reload_single_cycle: assert property (
        @(posedge clock) disable iff (!reset) count_bus.reload |=> !count_bus.reload
    );

endmodule

`default_nettype wire

// File: compare_bank.sv
/*
  Double-buffered compare registers for each PWM channel. Writes land in
  the shadows, which move to the active set at a period end or while the
  counter is stopped. Matches are registered and only fire on counter steps.
*/
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defs.svh"

module compare_bank import pwm_pkg::*; (
    input  logic clock,
    input  logic reset,
    count_if.buffer count_bus,
    input  logic compare_write,
    input  logic [`PWM_INDEX_WIDTH-1:0] compare_index,
    input  count_t compare_value,
    output logic [`PWM_CHANNELS-1:0] match_high,
    output logic [`PWM_CHANNELS-1:0] match_low
);

    count_t shadow_high [`PWM_CHANNELS];
    count_t shadow_low [`PWM_CHANNELS];
    count_t active_high [`PWM_CHANNELS];
    count_t active_low [`PWM_CHANNELS];
    count_t last_count;
    logic last_down;
    logic take_shadow;
    logic stepped;

    assign take_shadow = count_bus.reload || !count_bus.running;

    // A change of count or direction marks a timebase step
    assign stepped = count_bus.running &&
                     (count_bus.count != last_count || count_bus.counting_down != last_down);

    always_ff @(posedge clock) begin
        if (!reset) begin
            last_count <= '0;
            last_down <= 1'b0;
            match_high <= '0;
            match_low <= '0;
            for (int i = 0; i < `PWM_CHANNELS; i++) begin
                shadow_high[i] <= '0;
                shadow_low[i] <= '0;
                active_high[i] <= '0;
                active_low[i] <= '0;
            end
        end else begin
            last_count <= count_bus.count;
            last_down <= count_bus.counting_down;
            for (int i = 0; i < `PWM_CHANNELS; i++) begin
                if (compare_write && compare_index == 2 * i) begin
                    shadow_high[i] <= compare_value;
                end
                if (compare_write && compare_index == 2 * i + 1) begin
                    shadow_low[i] <= compare_value;
                end
                if (take_shadow) begin
                    active_high[i] <= shadow_high[i];
                    active_low[i] <= shadow_low[i];
                end
                // The first count of a new period already sees the new compares
                match_high[i] <= stepped &&
                    count_bus.count == (take_shadow ? shadow_high[i] : active_high[i]);
                match_low[i] <= stepped &&
                    count_bus.count == (take_shadow ? shadow_low[i] : active_low[i]);
            end
        end
    end

    compare_index_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        compare_write |-> compare_index[`PWM_INDEX_WIDTH-1:1] < `PWM_CHANNELS
    );

endmodule

`default_nettype wire

// File: pwm_output_stage.sv
/*
  Gate drive stage of the PWM chain. Each channel turns compare matches
  into a complementary pair, then delays rising edges by its dead time.
  Both sides of a channel are held low while it is stopped or disabled.
*/
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_output_stage import pwm_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic running,
    input  logic [`PWM_CHANNELS-1:0] match_high,
    input  logic [`PWM_CHANNELS-1:0] match_low,
    input  logic [`PWM_CHANNELS-1:0] output_enable,
    input  logic [`PWM_CHANNELS-1:0] dead_time_enable,
    input  dead_time_t [`PWM_CHANNELS-1:0] dead_times,
    output logic [`PWM_CHANNELS-1:0] out_a,
    output logic [`PWM_CHANNELS-1:0] out_b
);

    genvar ch;
    generate
        for (ch = 0; ch < `PWM_CHANNELS; ch++) begin : channel
            logic active;
            logic pin_next;
            logic raw_a;
            logic raw_b;
            logic last_a;
            logic last_b;
            logic changed;
            logic gate_a;
            logic gate_b;
            dead_time_t elapsed;
            dead_time_t since;

            assign active = running && output_enable[ch];

            // Set wins over clear when both matches land together
            assign pin_next = active && (match_high[ch] || (raw_a && !match_low[ch]));

            always_ff @(posedge clock) begin
                if (!reset) begin
                    raw_a <= 1'b0;
                    raw_b <= 1'b0;
                end else begin
                    raw_a <= pin_next;
                    raw_b <= active && !pin_next;
                end
            end

            // Cycles since the raw pair last switched, saturating
            assign changed = raw_a != last_a || raw_b != last_b;
            assign since = changed ? '0 : elapsed;

            always_ff @(posedge clock) begin
                if (!reset) begin
                    last_a <= 1'b0;
                    last_b <= 1'b0;
                    elapsed <= '0;
                    gate_a <= 1'b0;
                    gate_b <= 1'b0;
                end else begin
                    last_a <= raw_a;
                    last_b <= raw_b;
                    if (since != '1) begin
                        elapsed <= since + 1'b1;
                    end else begin
                        elapsed <= since;
                    end
                    if (dead_time_enable[ch]) begin
                        gate_a <= raw_a && since >= dead_times[ch];
                        gate_b <= raw_b && since >= dead_times[ch];
                    end else begin
                        gate_a <= raw_a;
                        gate_b <= raw_b;
                    end
                end
            end

            assign out_a[ch] = gate_a;
            assign out_b[ch] = gate_b;

            // With dead time on, neither side switches on straight after the other was on
            no_shoot_through: assert property (
                @(posedge clock) disable iff (!reset)
                ($rose(out_a[ch]) || $rose(out_b[ch])) &&
                    $past(dead_time_enable[ch] && dead_times[ch] != '0)
                |-> !$past(out_a[ch] || out_b[ch])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: pwm_chain.sv
/*
  Top level of one three-channel PWM chain. Registers set up a shared
  counter, a double-buffered compare bank and a dead-time output stage.
  The counter runs on the run bit or external_run unless stop_request is set.
*/
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_chain import pwm_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic timebase,
    input  logic sync,
    input  logic external_run,
    input  logic stop_request,
    input  logic reg_write,
    input  reg_addr_t reg_address,
    input  count_t reg_data,
    output logic counter_status,
    output logic [`PWM_CHANNELS-1:0] out_a,
    output logic [`PWM_CHANNELS-1:0] out_b
);

    logic run;
    logic run_request;
    counter_mode_t mode;
    count_t delay;
    count_t start_value;
    count_t stop_value;
    logic compare_write;
    logic [`PWM_INDEX_WIDTH-1:0] compare_index;
    count_t compare_value;
    logic [`PWM_CHANNELS-1:0] output_enable;
    logic [`PWM_CHANNELS-1:0] dead_time_enable;
    dead_time_t [`PWM_CHANNELS-1:0] dead_times;
    logic [`PWM_CHANNELS-1:0] match_high;
    logic [`PWM_CHANNELS-1:0] match_low;

    count_if count_bus ();

    assign run_request = (run || external_run) && !stop_request;
    assign counter_status = count_bus.running;

    pwm_registers registers (
        .clock(clock),
        .reset(reset),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .run(run),
        .mode(mode),
        .delay(delay),
        .start_value(start_value),
        .stop_value(stop_value),
        .compare_write(compare_write),
        .compare_index(compare_index),
        .compare_value(compare_value),
        .output_enable(output_enable),
        .dead_time_enable(dead_time_enable),
        .dead_times(dead_times)
    );

    pwm_counter counter (
        .clock(clock),
        .reset(reset),
        .timebase(timebase),
        .sync(sync),
        .run_request(run_request),
        .mode(mode),
        .delay(delay),
        .start_value(start_value),
        .stop_value(stop_value),
        .count_bus(count_bus.producer)
    );

    compare_bank compares (
        .clock(clock),
        .reset(reset),
        .count_bus(count_bus.buffer),
        .compare_write(compare_write),
        .compare_index(compare_index),
        .compare_value(compare_value),
        .match_high(match_high),
        .match_low(match_low)
    );

    pwm_output_stage outputs (
        .clock(clock),
        .reset(reset),
        .running(count_bus.running),
        .match_high(match_high),
        .match_low(match_low),
        .output_enable(output_enable),
        .dead_time_enable(dead_time_enable),
        .dead_times(dead_times),
        .out_a(out_a),
        .out_b(out_b)
    );

endmodule

`default_nettype wire

// File: pwm_chain_tb.sv
/*
  Testbench for the PWM chain. Drives seeded random register setups,
  timebase pulses, sync and run control, and compares counter_status,
  out_a and out_b on every cycle with a cycle-accurate model of the chain.
*/
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defs.svh"

module pwm_chain_tb import pwm_pkg::*; ();

    localparam int CLOCK_PERIOD = 10;
    localparam int ROUNDS = 8;
    localparam int RUN_CYCLES = 300;
    localparam int MAX_DELAY = 20;
    localparam int TEST_CYCLES = 60 + ROUNDS * (RUN_CYCLES + 3 * MAX_DELAY);

    logic clock;
    logic reset;
    logic timebase;
    logic sync;
    logic external_run;
    logic stop_request;
    logic reg_write;
    reg_addr_t reg_address;
    count_t reg_data;
    logic counter_status;
    logic [`PWM_CHANNELS-1:0] out_a;
    logic [`PWM_CHANNELS-1:0] out_b;

    // Settings of the current round
    logic mode_bit;
    int delay_value;
    int start_value;
    int stop_value;
    logic checking;

    // Reference model state, advanced on every rising edge
    logic m_run, m_mode, m_cw, m_reload, m_running, m_down, m_last_down;
    int m_delay, m_start, m_stop, m_cidx, m_cval, m_dcount, m_count, m_last_count;
    counter_state_t m_state;
    logic [`PWM_CHANNELS-1:0] m_oe, m_dte, m_mh, m_ml;
    logic [`PWM_CHANNELS-1:0] raw_a, raw_b, last_a, last_b, exp_a, exp_b;
    int m_dt [`PWM_CHANNELS];
    int sh_hi [`PWM_CHANNELS];
    int sh_lo [`PWM_CHANNELS];
    int ac_hi [`PWM_CHANNELS];
    int ac_lo [`PWM_CHANNELS];
    int elapsed [`PWM_CHANNELS];

    // Cycles since each output last fell, for the dead-time gap check
    int fall_age_a [`PWM_CHANNELS] = '{default: 1000};
    int fall_age_b [`PWM_CHANNELS] = '{default: 1000};
    logic [`PWM_CHANNELS-1:0] prev_a = '0;
    logic [`PWM_CHANNELS-1:0] prev_b = '0;

    pwm_chain UUT (
        .clock(clock),
        .reset(reset),
        .timebase(timebase),
        .sync(sync),
        .external_run(external_run),
        .stop_request(stop_request),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_data(reg_data),
        .counter_status(counter_status),
        .out_a(out_a),
        .out_b(out_b)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(posedge clock) begin : reference_model
        int since;
        logic active;
        logic pin_next;
        logic take;
        logic stepped;
        logic request;
        logic old_running;
        if (!reset) begin
            {m_run, m_mode, m_cw, m_reload, m_running, m_down, m_last_down} = '0;
            {m_delay, m_start, m_stop, m_dcount, m_count, m_last_count} = '0;
            m_state = state_idle;
            {m_oe, m_dte, m_mh, m_ml, raw_a, raw_b, last_a, last_b, exp_a, exp_b} = '0;
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                m_dt[ch] = 0;
                sh_hi[ch] = 0;
                sh_lo[ch] = 0;
                ac_hi[ch] = 0;
                ac_lo[ch] = 0;
                elapsed[ch] = 0;
            end
        end else begin
            // Output stage first, so every stage sees its inputs from before the edge
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                active = m_running && m_oe[ch];
                pin_next = active && (m_mh[ch] || (raw_a[ch] && !m_ml[ch]));
                since = (raw_a[ch] != last_a[ch] || raw_b[ch] != last_b[ch]) ? 0 : elapsed[ch];
                exp_a[ch] = raw_a[ch] && (!m_dte[ch] || since >= m_dt[ch]);
                exp_b[ch] = raw_b[ch] && (!m_dte[ch] || since >= m_dt[ch]);
                elapsed[ch] = (since < 16'hffff) ? since + 1 : since;
                last_a[ch] = raw_a[ch];
                last_b[ch] = raw_b[ch];
                raw_a[ch] = pin_next;
                raw_b[ch] = active && !pin_next;
            end
            // Compare bank: shadows go live at a period end or while stopped
            take = m_reload || !m_running;
            stepped = m_running && (m_count != m_last_count || m_down != m_last_down);
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                m_mh[ch] = stepped && m_count == (take ? sh_hi[ch] : ac_hi[ch]);
                m_ml[ch] = stepped && m_count == (take ? sh_lo[ch] : ac_lo[ch]);
                if (take) begin
                    ac_hi[ch] = sh_hi[ch];
                    ac_lo[ch] = sh_lo[ch];
                end
                if (m_cw && m_cidx == 2 * ch) begin
                    sh_hi[ch] = m_cval;
                end
                if (m_cw && m_cidx == 2 * ch + 1) begin
                    sh_lo[ch] = m_cval;
                end
            end
            m_last_count = m_count;
            m_last_down = m_down;
            // Counter
            request = (m_run || external_run) && !stop_request;
            old_running = m_running;
            m_running = (m_state == state_run) && request;
            m_reload = 1'b0;
            case (m_state)
                state_idle: begin
                    if (request && m_delay == 0) begin
                        m_state = state_run;
                        m_count = m_start;
                        m_down = 1'b0;
                    end else if (request) begin
                        m_state = state_delay;
                        m_dcount = m_delay - 1;
                    end
                end
                state_delay: begin
                    if (!request) begin
                        m_state = state_idle;
                    end else if (m_dcount == 0) begin
                        m_state = state_run;
                        m_count = m_start;
                        m_down = 1'b0;
                    end else begin
                        m_dcount = m_dcount - 1;
                    end
                end
                default: begin
                    if (!request) begin
                        m_state = state_idle;
                    end else if (sync) begin
                        m_count = m_start;
                        m_down = 1'b0;
                        m_reload = 1'b1;
                    end else if (timebase && old_running) begin
                        if (!m_mode) begin
                            // Sawtooth wraps from stop back to start
                            m_down = 1'b0;
                            m_reload = (m_count == m_stop);
                            m_count = (m_count == m_stop) ? m_start : m_count + 1;
                        end else if (!m_down) begin
                            m_down = (m_count == m_stop);
                            m_count = (m_count == m_stop) ? m_count - 1 : m_count + 1;
                        end else if (m_count == m_start) begin
                            m_down = 1'b0;
                            m_count = m_count + 1;
                            m_reload = 1'b1;
                        end else begin
                            m_count = m_count - 1;
                        end
                    end
                end
            endcase
            // Register file
            m_cw = reg_write && reg_address >= `PWM_REG_COMPARE_BASE &&
                   reg_address < `PWM_REG_COMPARE_BASE + 2 * `PWM_CHANNELS;
            if (m_cw) begin
                m_cidx = reg_address - `PWM_REG_COMPARE_BASE;
                m_cval = reg_data;
            end
            if (reg_write && reg_address >= `PWM_REG_DEADTIME_BASE &&
                reg_address < `PWM_REG_DEADTIME_BASE + `PWM_CHANNELS) begin
                m_dt[reg_address - `PWM_REG_DEADTIME_BASE] = reg_data;
            end
            if (reg_write) begin
                case (reg_address)
                    `PWM_REG_CONTROL: {m_mode, m_run} = reg_data[1:0];
                    `PWM_REG_DELAY: m_delay = reg_data;
                    `PWM_REG_START: m_start = reg_data;
                    `PWM_REG_STOP: m_stop = reg_data;
                    `PWM_REG_OUTPUT: {m_dte, m_oe} = {reg_data[6:4], reg_data[2:0]};
                    default: ;
                endcase
            end
        end
    end

    // Outputs are compared on the falling edge, half a cycle after they settle
    always @(negedge clock) begin
        if (checking) begin
            check_value("counter_status", m_running, counter_status);
            check_value("out_a & out_b", 0, out_a & out_b);
            for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
                fall_age_a[ch] = (prev_a[ch] && !out_a[ch]) ? 0 : fall_age_a[ch] + 1;
                fall_age_b[ch] = (prev_b[ch] && !out_b[ch]) ? 0 : fall_age_b[ch] + 1;
                if (m_dte[ch] && out_a[ch] && !prev_a[ch]) begin
                    check_value("dead time before out_a rise", 1, fall_age_b[ch] >= m_dt[ch]);
                end
                if (m_dte[ch] && out_b[ch] && !prev_b[ch]) begin
                    check_value("dead time before out_b rise", 1, fall_age_a[ch] >= m_dt[ch]);
                end
            end
            check_value("out_a", exp_a, out_a);
            check_value("out_b", exp_b, out_b);
            prev_a = out_a;
            prev_b = out_b;
        end
    end

    task automatic next_cycle;
        @(negedge clock);
        timebase = $urandom_range(0, 1);
        reg_write = 1'b0;
        sync = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t address, input count_t data);
        next_cycle();
        reg_write = 1'b1;
        reg_address = address;
        reg_data = data;
    endtask

    task automatic configure_round(input int round_index);
        logic [2:0] enables;
        logic [2:0] dead_enables;
        mode_bit = round_index[1];
        delay_value = $urandom_range(0, MAX_DELAY);
        start_value = $urandom_range(0, 20);
        stop_value = start_value + $urandom_range(4, 40);
        enables = (round_index == 0) ? 3'b111 : 3'($urandom_range(0, 7));
        dead_enables = (round_index == 0) ? 3'b000 : 3'($urandom_range(0, 7));
        write_reg(`PWM_REG_CONTROL, {14'd0, mode_bit, 1'b0});
        write_reg(`PWM_REG_DELAY, delay_value);
        write_reg(`PWM_REG_START, start_value);
        write_reg(`PWM_REG_STOP, stop_value);
        for (int index = 0; index < 2 * `PWM_CHANNELS; index++) begin
            write_reg(`PWM_REG_COMPARE_BASE + index, $urandom_range(start_value, stop_value));
        end
        for (int ch = 0; ch < `PWM_CHANNELS; ch++) begin
            write_reg(`PWM_REG_DEADTIME_BASE + ch, $urandom_range(0, 7));
        end
        write_reg(`PWM_REG_OUTPUT, {9'd0, dead_enables, 1'b0, enables});
    endtask

    task automatic run_period_traffic;
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            next_cycle();
            if (cycle == RUN_CYCLES / 2) begin
                sync = 1'b1;
            end else if ($urandom_range(0, 15) == 0) begin
                // Mid-period compare update that waits in the shadow for the reload
                reg_write = 1'b1;
                reg_address = `PWM_REG_COMPARE_BASE + $urandom_range(0, 2 * `PWM_CHANNELS - 1);
                reg_data = $urandom_range(start_value, stop_value);
            end
        end
    endtask

    task automatic stop_counter;
        next_cycle();
        stop_request = 1'b1;
        external_run = 1'b0;
        next_cycle();
        check_value("counter_status after stop", 0, counter_status);
        next_cycle();
        next_cycle();
        check_value("out_a | out_b after stop", 0, out_a | out_b);
        write_reg(`PWM_REG_CONTROL, {14'd0, mode_bit, 1'b0});
        next_cycle();
        stop_request = 1'b0;
    endtask

    initial begin : stimulus
        int seed_result;
        int cycles;
        seed_result = $urandom(32'hb18d_ed30);
        checking = 1'b0;
        reset = 1'b0;
        timebase = 1'b0;
        sync = 1'b0;
        external_run = 1'b0;
        stop_request = 1'b0;
        reg_write = 1'b0;
        reg_address = '0;
        reg_data = '0;
        mode_bit = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        checking = 1'b1;

        // With run low the timebase alone must not start anything
        repeat (50) next_cycle();

        for (int round = 0; round < ROUNDS; round++) begin
            configure_round(round);
            if (round % 2 == 0) begin
                write_reg(`PWM_REG_CONTROL, {14'd0, mode_bit, 1'b1});
            end else begin
                next_cycle();
                external_run = 1'b1;
            end
            // Latency counts from the first edge that sees the start
            next_cycle();
            cycles = 0;
            while (!counter_status) begin
                next_cycle();
                cycles++;
            end
            check_value("start latency", delay_value + ((round % 2 == 0) ? 2 : 1), cycles);
            run_period_traffic();
            stop_counter();
        end

        $display("STATUS: PASS");
        $finish;
    end

    initial begin : watchdog
        #((TEST_CYCLES + 1000) * CLOCK_PERIOD);
        $display("Watchdog expired: the run hung before all tests finished");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
pwm_pkg.sv
count_if.sv
pwm_registers.sv
pwm_counter.sv
compare_bank.sv
pwm_output_stage.sv
pwm_chain.sv
pwm_chain_tb.sv
